/* heapMemory.f */
heapGeometryPkg.sv
heapTypesPkg.sv
heapRequestStage.sv
heapAllocator.sv
heapArrayStore.sv
heapResponseStage.sv
heapMemory.sv
tbClock.sv
heapMemory_assertions.sv
heapMemory_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  --top-module heapMemory_tb -f heapMemory.f -Mdir obj_dir
	./obj_dir/VheapMemory_tb | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* heapMemory_tb.sv */
/*
  Heap memory testbench: reference model, request and response tasks,
  directed tests, watchdog and final report
*/
`timescale 1ns/10ps
`default_nettype none

module heapMemory_tb;

  localparam int MaxArrays   = 4;
  localparam int ResetCycles = 8;
  localparam int NumArrays   = heapGeometryPkg::NumArrays;
  localparam int ArrayLength = heapGeometryPkg::ArrayLength;

  logic                       clock;
  logic                       reset;
  logic                       reqValid;
  heapTypesPkg::heapRequestT  req;
  logic                       respValid;
  heapTypesPkg::heapResponseT resp;

  int                         errorCount = 0;
  int                         issued = 0;           // Requests sent so far
  integer                     seed;
  heapTypesPkg::heapResponseT expQueue [$];
  heapTypesPkg::heapResponseT gotQueue [$];
  heapTypesPkg::heapResponseT lastResp;

  logic modelLive [NumArrays];
  int   modelSize [NumArrays];
  int   modelMem  [NumArrays][ArrayLength];
  int   modelNext;
  int   modelFreed [$];                           // LIFO of freed numbers

  tbClock #(.Period(10), .ResetCycles(ResetCycles)) clockGen (
    .clock (clock),
    .reset (reset)
  );

  heapMemory #(.MaxArrays(MaxArrays)) u_heapMemory (
    .clock     (clock),
    .reset     (reset),
    .reqValid  (reqValid),
    .req       (req),
    .respValid (respValid),
    .resp      (resp)
  );

  always @(negedge clock) begin
    if (respValid) begin
      gotQueue.push_back(resp);                   // Sampled mid-cycle
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  task automatic modelClear();
    for (int i = 0; i < NumArrays; i++) begin
      modelLive[i] = 1'b0;
      modelSize[i] = 0;
    end
    modelNext = 0;
    modelFreed.delete();
  endtask

  task automatic modelApply(input heapTypesPkg::heapActionT action, input int array,
                            input int index, input int data,
                            output heapTypesPkg::heapResponseT expected);
    heapTypesPkg::heapErrorT err;
    int                      result;
    logic                    arrayFree;
    err       = heapTypesPkg::none;
    result    = 0;
    arrayFree = 1'b0;
    if (int'(action) <= 11 && action != heapTypesPkg::clearAll &&
        action != heapTypesPkg::alloc) begin
      arrayFree = (array >= MaxArrays) || !modelLive[array];
    end
    if (int'(action) > 11) begin
      err = heapTypesPkg::badAction;
    end else if (arrayFree) begin
      err = heapTypesPkg::notAllocated;
    end else if ((action == heapTypesPkg::read || action == heapTypesPkg::add) &&
                 index >= modelSize[array]) begin
      err = heapTypesPkg::outOfBounds;
    end else if (action == heapTypesPkg::push && modelSize[array] == ArrayLength) begin
      err = heapTypesPkg::full;
    end else if (action == heapTypesPkg::pop && modelSize[array] == 0) begin
      err = heapTypesPkg::empty;
    end else if (action == heapTypesPkg::alloc && modelFreed.size() == 0 &&
                 modelNext >= MaxArrays) begin
      err = heapTypesPkg::outOfMemory;
    end
    if (err == heapTypesPkg::none) begin
      case (action)
        heapTypesPkg::clearAll: modelClear();
        heapTypesPkg::alloc: begin
          if (modelFreed.size() > 0) begin
            result = modelFreed.pop_back();     // Most recently freed first
          end else begin
            result    = modelNext;
            modelNext = modelNext + 1;
          end
          modelLive[result] = 1'b1;
          modelSize[result] = 0;
        end
        heapTypesPkg::free: begin
          modelLive[array] = 1'b0;
          modelFreed.push_back(array);
        end
        heapTypesPkg::write: begin
          modelMem[array][index] = data;
          if (index + 1 > modelSize[array]) begin
            modelSize[array] = index + 1;
          end
          result = data;
        end
        heapTypesPkg::read: result = modelMem[array][index];
        heapTypesPkg::size: result = modelSize[array];
        heapTypesPkg::push: begin
          modelMem[array][modelSize[array]] = data;
          modelSize[array] = modelSize[array] + 1;
        end
        heapTypesPkg::pop: begin
          modelSize[array] = modelSize[array] - 1;
          result = modelMem[array][modelSize[array]];
        end
        heapTypesPkg::countLess, heapTypesPkg::countGreater, heapTypesPkg::indexOf: begin
          for (int i = 0; i < modelSize[array]; i++) begin
            if (action == heapTypesPkg::countLess && modelMem[array][i] < data) begin
              result = result + 1;
            end
            if (action == heapTypesPkg::countGreater && modelMem[array][i] > data) begin
              result = result + 1;
            end
            if (action == heapTypesPkg::indexOf && modelMem[array][i] == data) begin
              result = i + 1;                   // Last match counts
            end
          end
        end
        heapTypesPkg::add: begin
          result = (modelMem[array][index] + data) % 4096;
          modelMem[array][index] = result;
        end
        default: result = 0;
      endcase
    end
    expected.data  = heapGeometryPkg::dataT'(result);
    expected.error = err;
  endtask

  // ----------------------------------------
  // Request and response handling
  // ----------------------------------------

  task automatic compareResponse(input string what, input heapTypesPkg::heapResponseT got,
                                 input int expData, input heapTypesPkg::heapErrorT expErr);
    if (int'(got.data) !== expData) begin
      $display("mismatch %s resp.data: got 0x%h, expected 0x%h", what, got.data, expData);
      errorCount++;
    end
    if (got.error !== expErr) begin
      $display("mismatch %s resp.error: got 0x%h, expected 0x%h", what, got.error, expErr);
      errorCount++;
    end
  endtask

  task automatic issue(input heapTypesPkg::heapActionT action, input int array,
                       input int index, input int data);
    heapTypesPkg::heapResponseT expected;
    @(negedge clock);
    reqValid   = 1'b1;
    req.action = action;
    req.array  = heapGeometryPkg::arrayNumT'(array);
    req.index  = heapGeometryPkg::indexT'(index);
    req.data   = heapGeometryPkg::dataT'(data);
    modelApply(action, array, index, data, expected);
    expQueue.push_back(expected);
    issued++;
  endtask

  task automatic dropStrobe();
    @(negedge clock);
    reqValid = 1'b0;
  endtask

  task automatic awaitResponses(input int count);
    heapTypesPkg::heapResponseT expected;
    int                         waited;
    waited = 0;
    while (gotQueue.size() < count && waited < 10) begin
      @(posedge clock);
      waited++;
    end
    if (gotQueue.size() < count) begin
      $display("no response within 10 cycles, %0d of %0d arrived", gotQueue.size(), count);
      errorCount++;
      gotQueue.delete();
      expQueue.delete();
      return;
    end
    while (gotQueue.size() > 0) begin
      lastResp = gotQueue.pop_front();
      if (expQueue.size() == 0) begin
        $display("response arrived with no request outstanding");
        errorCount++;
      end else begin
        expected = expQueue.pop_front();
        compareResponse("model", lastResp, int'(expected.data), expected.error);
      end
    end
  endtask

  task automatic transact(input heapTypesPkg::heapActionT action, input int array,
                          input int index, input int data);
    issue(action, array, index, data);
    dropStrobe();
    awaitResponses(1);
  endtask

  task automatic checkLast(input string what, input int expData,
                           input heapTypesPkg::heapErrorT expErr);
    compareResponse(what, lastResp, expData, expErr);
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic testAllocation();
    for (int i = 0; i < 4; i++) begin
      transact(heapTypesPkg::alloc, 0, 0, 0);
      checkLast("alloc in order", i, heapTypesPkg::none);
    end
    transact(heapTypesPkg::alloc, 0, 0, 0);
    checkLast("alloc with none left", 0, heapTypesPkg::outOfMemory);
    transact(heapTypesPkg::free, 2, 0, 0);
    transact(heapTypesPkg::free, 0, 0, 0);
    transact(heapTypesPkg::alloc, 0, 0, 0);
    checkLast("alloc reuses last freed", 0, heapTypesPkg::none);
    transact(heapTypesPkg::alloc, 0, 0, 0);
    checkLast("alloc reuses earlier freed", 2, heapTypesPkg::none);
    transact(heapTypesPkg::free, 1, 0, 0);
    transact(heapTypesPkg::free, 1, 0, 0);
    checkLast("free of free array", 0, heapTypesPkg::notAllocated);
    transact(heapTypesPkg::clearAll, 0, 0, 0);
    checkLast("clearAll", 0, heapTypesPkg::none);
    transact(heapTypesPkg::alloc, 0, 0, 0);
    checkLast("alloc after clearAll", 0, heapTypesPkg::none);
  endtask

  task automatic testWriteRead();
    int   idx;
    int   value;
    int   highest;
    int   written [ArrayLength];
    logic seen    [ArrayLength];
    highest = -1;
    for (int i = 0; i < ArrayLength; i++) begin
      seen[i] = 1'b0;
    end
    transact(heapTypesPkg::clearAll, 0, 0, 0);
    transact(heapTypesPkg::alloc, 0, 0, 0);
    repeat (6) begin
      idx   = $random(seed) & 3;
      value = $random(seed) & 'hfff;
      transact(heapTypesPkg::write, 0, idx, value);
      checkLast("write echo", value, heapTypesPkg::none);
      written[idx] = value;
      seen[idx]    = 1'b1;
      if (idx > highest) begin
        highest = idx;
      end
      transact(heapTypesPkg::size, 0, 0, 0);
      checkLast("size after write", highest + 1, heapTypesPkg::none);
    end
    for (int i = 0; i < ArrayLength; i++) begin
      if (seen[i]) begin
        transact(heapTypesPkg::read, 0, i, 0);
        checkLast("read back", written[i], heapTypesPkg::none);
      end
    end
    transact(heapTypesPkg::alloc, 0, 0, 0);       // Array 1 left short
    transact(heapTypesPkg::write, 1, 1, 'h5a5);
    transact(heapTypesPkg::read, 1, 2, 0);
    checkLast("read at size", 0, heapTypesPkg::outOfBounds);
    transact(heapTypesPkg::read, 1, 3, 0);
    checkLast("read beyond size", 0, heapTypesPkg::outOfBounds);
  endtask

  task automatic testPushPop();
    int pushed [ArrayLength];
    transact(heapTypesPkg::clearAll, 0, 0, 0);
    transact(heapTypesPkg::alloc, 0, 0, 0);
    for (int i = 0; i < ArrayLength; i++) begin
      pushed[i] = $random(seed) & 'hfff;
      transact(heapTypesPkg::push, 0, 0, pushed[i]);
      checkLast("push", 0, heapTypesPkg::none);
    end
    transact(heapTypesPkg::push, 0, 0, 'h123);
    checkLast("push on full array", 0, heapTypesPkg::full);
    for (int i = ArrayLength - 1; i >= 0; i--) begin
      transact(heapTypesPkg::pop, 0, 0, 0);
      checkLast("pop in reverse", pushed[i], heapTypesPkg::none);
    end
    transact(heapTypesPkg::pop, 0, 0, 0);
    checkLast("pop on empty array", 0, heapTypesPkg::empty);
  endtask

  task automatic testSearch();
    transact(heapTypesPkg::clearAll, 0, 0, 0);
    transact(heapTypesPkg::alloc, 0, 0, 0);
    transact(heapTypesPkg::push, 0, 0, 10);
    transact(heapTypesPkg::push, 0, 0, 20);
    transact(heapTypesPkg::push, 0, 0, 30);
    transact(heapTypesPkg::countLess, 0, 0, 20);
    checkLast("countLess 20", 1, heapTypesPkg::none);
    transact(heapTypesPkg::countGreater, 0, 0, 20);
    checkLast("countGreater 20", 1, heapTypesPkg::none);
    transact(heapTypesPkg::indexOf, 0, 0, 30);
    checkLast("indexOf 30", 3, heapTypesPkg::none);
    transact(heapTypesPkg::indexOf, 0, 0, 25);
    checkLast("indexOf missing", 0, heapTypesPkg::none);
  endtask

  task automatic testAddAndBursts();
    int value;
    transact(heapTypesPkg::clearAll, 0, 0, 0);
    transact(heapTypesPkg::alloc, 0, 0, 0);
    transact(heapTypesPkg::write, 0, 0, 4000);
    transact(heapTypesPkg::add, 0, 0, 200);
    checkLast("add wraps", 104, heapTypesPkg::none);
    transact(heapTypesPkg::read, 0, 0, 0);
    checkLast("read after add", 104, heapTypesPkg::none);
    transact(heapTypesPkg::add, 0, 2, 1);
    checkLast("add past size", 0, heapTypesPkg::outOfBounds);
    value = $random(seed) & 'hfff;
    issue(heapTypesPkg::write, 0, 1, value);      // Read follows with no gap
    issue(heapTypesPkg::read, 0, 1, 0);
    dropStrobe();
    awaitResponses(2);
    checkLast("read right after write", value, heapTypesPkg::none);
    transact(heapTypesPkg::heapActionT'(4'd12), 0, 0, 0);
    checkLast("undefined action", 0, heapTypesPkg::badAction);
  endtask

  // ----------------------------------------
  // Run control
  // ----------------------------------------

  initial begin
    reqValid = 1'b0;
    req      = '0;
    seed     = 32'h52e2c5ee;
    modelClear();
    @(posedge reset);
    testAllocation();
    testWriteRead();
    testPushPop();
    testSearch();
    testAddAndBursts();
    repeat (4) @(negedge clock);
    if (gotQueue.size() != 0) begin
      $display("%0d responses arrived after the last request", gotQueue.size());
      errorCount++;
    end
    errorCount = errorCount + u_heapMemory.u_assertions.failCount;
    $display("Errors: %0d, requests issued: %0d", errorCount, issued);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Budget grows with each request sent
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < ResetCycles + 20 * (issued + 1)) begin
      @(posedge clock);
      cycles++;
    end
    $display("watchdog expired after %0d cycles with %0d requests issued", cycles, issued);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* heapMemory_assertions.sv */
/*
  Concurrent checks on the request and response strobes,
  bound into the heap memory top level
*/
`timescale 1ns/10ps
`default_nettype none

module heapMemory_assertions (
  input logic clock,
  input logic reset,
  input logic reqValid,
  input logic respValid
);

  int failCount = 0;                              // Failed assertion count

  // Two registers between the request and the response
  property respAfterReq;
    @(posedge clock) disable iff (!reset) $past(reqValid, 2) |-> respValid;
  endproperty

  property respHasReq;
    @(posedge clock) disable iff (!reset) respValid |-> $past(reqValid, 2);
  endproperty

  // Both pipeline registers leave reset empty
  property quietInReset;
    @(posedge clock) (!reset || !$past(reset, 2)) |-> !respValid;
  endproperty

  assert property (respAfterReq) else begin
    $error("request not followed by respValid two cycles later");
    failCount++;
  end

  assert property (respHasReq) else begin
    $error("respValid without a request two cycles earlier");
    failCount++;
  end

  assert property (quietInReset) else begin
    $error("respValid high during or just after reset");
    failCount++;
  end

endmodule

bind heapMemory heapMemory_assertions u_assertions (
  .clock     (clock),
  .reset     (reset),
  .reqValid  (reqValid),
  .respValid (respValid)
);

`default_nettype wire

/* tbClock.sv */
/*
  Testbench clock and reset generator
*/
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
  parameter int Period      = 10,                 // Clock period in ns
  parameter int ResetCycles = 8                   // Cycles with reset held low
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(Period / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b0;
    repeat (ResetCycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;                                 // Release away from the rising edge
  end

endmodule

`default_nettype wire

/* heapMemory.sv */
/*
  Heap memory top level: request stage, allocator, array store
  and response stage
*/
`timescale 1ns/10ps
`default_nettype none

module heapMemory #(
  parameter int MaxArrays = 4                      // Arrays that may be allocated
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       reqValid,
  input  heapTypesPkg::heapRequestT  req,
  output logic                       respValid,
  output heapTypesPkg::heapResponseT resp
);

  logic                      decValid;
  heapTypesPkg::heapDecodedT dec;
  heapTypesPkg::heapAllocT   allocInfo;
  heapGeometryPkg::dataT     storeData;
  heapTypesPkg::heapErrorT   storeError;

  heapRequestStage #(
    .MaxArrays (MaxArrays)
  ) u_requestStage (
    .clock     (clock),
    .reset     (reset),
    .reqValid  (reqValid),
    .req       (req),
    .decValid  (decValid),
    .dec       (dec)
  );

  heapAllocator #(
    .MaxArrays (MaxArrays)
  ) u_allocator (
    .clock     (clock),
    .reset     (reset),
    .decValid  (decValid),
    .dec       (dec),
    .allocInfo (allocInfo)
  );

  heapArrayStore u_arrayStore (
    .clock      (clock),
    .reset      (reset),
    .decValid   (decValid),
    .dec        (dec),
    .allocInfo  (allocInfo),
    .storeData  (storeData),
    .storeError (storeError)
  );

  heapResponseStage u_responseStage (
    .clock      (clock),
    .reset      (reset),
    .decValid   (decValid),
    .dec        (dec),
    .allocInfo  (allocInfo),
    .storeData  (storeData),
    .storeError (storeError),
    .respValid  (respValid),
    .resp       (resp)
  );

endmodule

`default_nettype wire

/* heapResponseStage.sv */
/*
  Response stage: merges allocator and store results and registers
  the response word with its strobe
*/
`timescale 1ns/10ps
`default_nettype none

module heapResponseStage (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       decValid,
  input  heapTypesPkg::heapDecodedT  dec,
  input  heapTypesPkg::heapAllocT    allocInfo,
  input  heapGeometryPkg::dataT      storeData,
  input  heapTypesPkg::heapErrorT    storeError,
  output logic                       respValid,
  output heapTypesPkg::heapResponseT resp
);

  heapTypesPkg::heapErrorT errorNext;
  heapGeometryPkg::dataT   dataNext;

  always_comb begin
    // Allocator errors outrank store errors
    if (allocInfo.error != heapTypesPkg::none) begin
      errorNext = allocInfo.error;
    end else begin
      errorNext = storeError;
    end
    if (errorNext != heapTypesPkg::none) begin
      dataNext = '0;                               // Errored requests return 0
    end else if (dec.action == heapTypesPkg::alloc) begin
      dataNext = heapGeometryPkg::dataT'(allocInfo.newArray);
    end else begin
      dataNext = storeData;
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      respValid <= 1'b0;
    end else begin
      respValid <= decValid;
    end
  end

  always_ff @(posedge clock) begin
    if (decValid) begin
      resp.data  <= dataNext;
      resp.error <= errorNext;
    end
  end

endmodule

`default_nettype wire

/* heapArrayStore.sv */
/*
  Array store: element memory and size table; bounds, empty and full
  checks, element actions, counts and search
*/
`timescale 1ns/10ps
`default_nettype none

module heapArrayStore (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      decValid,
  input  heapTypesPkg::heapDecodedT dec,
  input  heapTypesPkg::heapAllocT   allocInfo,
  output heapGeometryPkg::dataT     storeData,
  output heapTypesPkg::heapErrorT   storeError
);

  localparam int NumArrays   = heapGeometryPkg::NumArrays;
  localparam int ArrayLength = heapGeometryPkg::ArrayLength;

  heapGeometryPkg::dataT  mem [NumArrays][ArrayLength];
  heapGeometryPkg::sizeT  sizeTable [NumArrays];

  heapGeometryPkg::sizeT  curSize;
  heapGeometryPkg::sizeT  indexPlusOne;
  heapGeometryPkg::indexT pushSlot;
  heapGeometryPkg::indexT lastSlot;
  heapGeometryPkg::dataT  element;
  heapGeometryPkg::dataT  sum;
  heapGeometryPkg::sizeT  lessCount;
  heapGeometryPkg::sizeT  greaterCount;
  heapGeometryPkg::sizeT  matchPos;
  logic                   writeEnable;
  logic                   allocOk;
  logic                   clearOk;

  assign curSize      = sizeTable[dec.array];
  assign indexPlusOne = {1'b0, dec.index} + 1'b1;
  assign pushSlot     = heapGeometryPkg::indexT'(curSize);   // Valid when not full
  assign lastSlot     = heapGeometryPkg::indexT'(curSize - 1'b1);
  assign element      = mem[dec.array][dec.index];
  assign sum          = element + dec.data;                  // Wraps modulo 4096

  // ----------------------------------------
  // Counts and search over live elements
  // ----------------------------------------

  always_comb begin
    lessCount    = '0;
    greaterCount = '0;
    matchPos     = '0;
    for (int i = 0; i < ArrayLength; i++) begin
      if (i < int'(curSize)) begin
        if (mem[dec.array][i] < dec.data) begin
          lessCount = lessCount + 1'b1;
        end
        if (mem[dec.array][i] > dec.data) begin
          greaterCount = greaterCount + 1'b1;
        end
        if (mem[dec.array][i] == dec.data) begin
          matchPos = heapGeometryPkg::sizeT'(i + 1);      // Last match wins
        end
      end
    end
  end

  // ----------------------------------------
  // Checks and result
  // ----------------------------------------

  always_comb begin
    storeError = heapTypesPkg::none;
    if (dec.needsInBounds && {1'b0, dec.index} >= curSize) begin
      storeError = heapTypesPkg::outOfBounds;
    end
    if (dec.action == heapTypesPkg::push &&
        curSize == heapGeometryPkg::sizeT'(ArrayLength)) begin
      storeError = heapTypesPkg::full;
    end
    if (dec.action == heapTypesPkg::pop && curSize == '0) begin
      storeError = heapTypesPkg::empty;
    end
  end

  always_comb begin
    case (dec.action)
      heapTypesPkg::write:        storeData = dec.data;
      heapTypesPkg::read:         storeData = element;
      heapTypesPkg::size:         storeData = heapGeometryPkg::dataT'(curSize);
      heapTypesPkg::pop:          storeData = mem[dec.array][lastSlot];
      heapTypesPkg::countLess:    storeData = heapGeometryPkg::dataT'(lessCount);
      heapTypesPkg::countGreater: storeData = heapGeometryPkg::dataT'(greaterCount);
      heapTypesPkg::indexOf:      storeData = heapGeometryPkg::dataT'(matchPos);
      heapTypesPkg::add:          storeData = sum;
      default:                    storeData = '0;           // clearAll, free
    endcase
  end

  assign writeEnable = decValid && allocInfo.arrayOk && (storeError == heapTypesPkg::none);
  assign allocOk     = decValid && (dec.action == heapTypesPkg::alloc) &&
                       (allocInfo.error == heapTypesPkg::none);
  assign clearOk     = decValid && (dec.action == heapTypesPkg::clearAll);

  // ----------------------------------------
  // Write back
  // ----------------------------------------

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < NumArrays; i++) begin
        sizeTable[i] <= '0;
      end
    end else if (clearOk) begin
      for (int i = 0; i < NumArrays; i++) begin
        sizeTable[i] <= '0;
      end
    end else if (allocOk) begin
      sizeTable[allocInfo.newArray] <= '0;         // New array starts empty
    end else if (writeEnable) begin
      case (dec.action)
        heapTypesPkg::write: begin
          if ({1'b0, dec.index} >= curSize) begin
            sizeTable[dec.array] <= indexPlusOne;  // Grow to cover the index
          end
        end
        heapTypesPkg::push: sizeTable[dec.array] <= curSize + 1'b1;
        heapTypesPkg::pop:  sizeTable[dec.array] <= curSize - 1'b1;
        default:            sizeTable[dec.array] <= curSize;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      case (dec.action)
        heapTypesPkg::write: mem[dec.array][dec.index] <= dec.data;
        heapTypesPkg::push:  mem[dec.array][pushSlot]  <= dec.data;
        heapTypesPkg::add:   mem[dec.array][dec.index] <= sum;
        default:             mem[dec.array][dec.index] <= element;
      endcase
    end
  end

endmodule

`default_nettype wire

/* heapAllocator.sv */
/*
  Array allocator: allocated flags, next-new counter and the LIFO
  stack of freed array numbers; performs clearAll, alloc and free
*/
`timescale 1ns/10ps
`default_nettype none

module heapAllocator #(
  parameter int MaxArrays = 4                     // At most NumArrays
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      decValid,
  input  heapTypesPkg::heapDecodedT dec,
  output heapTypesPkg::heapAllocT   allocInfo
);

  localparam int NumArrays = heapGeometryPkg::NumArrays;
  localparam int CountBits = heapGeometryPkg::AddressBits + 1;

  logic [NumArrays-1:0]      allocated;           // One flag per array
  logic [CountBits-1:0]      nextNew;             // Next never-used number
  logic [CountBits-1:0]      freedTop;            // Entries on the freed stack
  heapGeometryPkg::arrayNumT freedStack [NumArrays];
  heapGeometryPkg::arrayNumT topSlot;
  logic                      arrayOk;
  logic                      doUpdate;

  // ----------------------------------------
  // Lookup and allocation choice
  // ----------------------------------------

  assign topSlot = heapGeometryPkg::arrayNumT'(freedTop - 1'b1);
  assign arrayOk = allocated[dec.array] && !dec.rangeError;

  always_comb begin
    allocInfo.arrayOk  = arrayOk;
    allocInfo.newArray = '0;
    allocInfo.error    = heapTypesPkg::none;
    case (dec.action)
      heapTypesPkg::alloc: begin
        if (freedTop != '0) begin
          allocInfo.newArray = freedStack[topSlot];   // Reuse most recently freed
        end else if (int'(nextNew) < MaxArrays) begin
          allocInfo.newArray = heapGeometryPkg::arrayNumT'(nextNew);
        end else begin
          allocInfo.error = heapTypesPkg::outOfMemory;
        end
      end
      heapTypesPkg::clearAll,
      heapTypesPkg::free,
      heapTypesPkg::write,
      heapTypesPkg::read,
      heapTypesPkg::size,
      heapTypesPkg::push,
      heapTypesPkg::pop,
      heapTypesPkg::countLess,
      heapTypesPkg::countGreater,
      heapTypesPkg::indexOf,
      heapTypesPkg::add: begin
        allocInfo.error = heapTypesPkg::none;
      end
      default: begin
        allocInfo.error = heapTypesPkg::badAction;
      end
    endcase
    if (dec.needsAllocated && !arrayOk) begin
      allocInfo.error = heapTypesPkg::notAllocated;   // Also covers rangeError
    end
  end

  assign doUpdate = decValid && (allocInfo.error == heapTypesPkg::none);

  // ----------------------------------------
  // State update
  // ----------------------------------------

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated <= '0;
      nextNew   <= '0;
      freedTop  <= '0;
    end else if (doUpdate) begin
      case (dec.action)
        heapTypesPkg::clearAll: begin
          allocated <= '0;
          nextNew   <= '0;
          freedTop  <= '0;                        // Stack contents are dropped
        end
        heapTypesPkg::alloc: begin
          allocated[allocInfo.newArray] <= 1'b1;
          if (freedTop != '0) begin
            freedTop <= freedTop - 1'b1;
          end else begin
            nextNew <= nextNew + 1'b1;
          end
        end
        heapTypesPkg::free: begin
          allocated[dec.array] <= 1'b0;           // Flag of the freed array itself
          freedTop             <= freedTop + 1'b1;
        end
        default: begin
          freedTop <= freedTop;
        end
      endcase
    end
  end

  // A live array cannot be freed twice, so the stack never overflows
  always_ff @(posedge clock) begin
    if (doUpdate && dec.action == heapTypesPkg::free) begin
      freedStack[heapGeometryPkg::arrayNumT'(freedTop)] <= dec.array;
    end
  end

endmodule

`default_nettype wire

/* heapRequestStage.sv */
/*
  Request stage: registers each request, derives its requirement
  flags and flags array numbers outside the configured range
*/
`timescale 1ns/10ps
`default_nettype none

module heapRequestStage #(
  parameter int MaxArrays = 4                     // Arrays that may be allocated
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      reqValid,
  input  heapTypesPkg::heapRequestT req,
  output logic                      decValid,
  output heapTypesPkg::heapDecodedT dec
);

  logic                      needsAllocated;
  logic                      needsInBounds;
  heapTypesPkg::heapDecodedT decNext;

  // ----------------------------------------
  // Classify the action
  // ----------------------------------------

  always_comb begin
    needsAllocated = 1'b0;
    needsInBounds  = 1'b0;
    case (req.action)
      heapTypesPkg::free,
      heapTypesPkg::write,
      heapTypesPkg::size,
      heapTypesPkg::push,
      heapTypesPkg::pop,
      heapTypesPkg::countLess,
      heapTypesPkg::countGreater,
      heapTypesPkg::indexOf: begin
        needsAllocated = 1'b1;
      end
      heapTypesPkg::read,
      heapTypesPkg::add: begin
        needsAllocated = 1'b1;
        needsInBounds  = 1'b1;                    // Element must already exist
      end
      default: begin
        needsAllocated = 1'b0;                    // clearAll, alloc, undefined
      end
    endcase
  end

  always_comb begin
    decNext.action         = req.action;
    decNext.array          = req.array;
    decNext.index          = req.index;
    decNext.data           = req.data;
    decNext.needsAllocated = needsAllocated;
    decNext.needsInBounds  = needsInBounds;
    decNext.rangeError     = needsAllocated && (int'(req.array) >= MaxArrays);
  end

  // ----------------------------------------
  // Pipeline register
  // ----------------------------------------

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      decValid <= 1'b0;
    end else begin
      decValid <= reqValid;                       // Every strobe is accepted
    end
  end

  always_ff @(posedge clock) begin
    if (reqValid) begin
      dec <= decNext;
    end
  end

endmodule

`default_nettype wire

/* heapTypesPkg.sv */
/*
  Heap protocol types: action and error codes, the external request,
  the decoded request, the allocator result and the response word
*/
`default_nettype none

package heapTypesPkg;

  // ----------------------------------------
  // Codes
  // ----------------------------------------

  typedef enum logic [3:0] {
    clearAll     = 4'd0,    // Free every array
    alloc        = 4'd1,    // Hand out an array number
    free         = 4'd2,    // Return an array for reuse
    write        = 4'd3,
    read         = 4'd4,
    size         = 4'd5,
    push         = 4'd6,
    pop          = 4'd7,
    countLess    = 4'd8,
    countGreater = 4'd9,
    indexOf      = 4'd10,   // One plus last matching position
    add          = 4'd11    // Returns the new value
  } heapActionT;            // Codes 12 to 15 are undefined

  typedef enum logic [2:0] {
    none         = 3'd0,
    notAllocated = 3'd1,
    outOfBounds  = 3'd2,
    empty        = 3'd3,
    full         = 3'd4,
    outOfMemory  = 3'd5,
    badAction    = 3'd6
  } heapErrorT;

  // ----------------------------------------
  // Words passed between blocks
  // ----------------------------------------

  typedef struct packed {
    heapActionT                action;
    heapGeometryPkg::arrayNumT array;
    heapGeometryPkg::indexT    index;
    heapGeometryPkg::dataT     data;
  } heapRequestT;                              // 20 bits

  typedef struct packed {
    heapActionT                action;
    heapGeometryPkg::arrayNumT array;
    heapGeometryPkg::indexT    index;
    heapGeometryPkg::dataT     data;
    logic                      needsAllocated; // Target array must be live
    logic                      needsInBounds;  // Index must be below size
    logic                      rangeError;     // Array number beyond MaxArrays
  } heapDecodedT;                              // 23 bits

  typedef struct packed {
    logic                      arrayOk;        // Target array is allocated
    heapGeometryPkg::arrayNumT newArray;       // Number handed out by alloc
    heapErrorT                 error;
  } heapAllocT;

  typedef struct packed {
    heapGeometryPkg::dataT     data;
    heapErrorT                 error;
  } heapResponseT;                             // 15 bits

endpackage

`default_nettype wire

/* heapGeometryPkg.sv */
/*
  Heap geometry: widths of array numbers, indices and elements,
  default array count and length, and the word types built on them
*/
`default_nettype none

package heapGeometryPkg;

  localparam int AddressBits = 2;                 // Bits in an array number
  localparam int IndexBits   = 2;                 // Bits in an element index
  localparam int DataBits    = 12;                // Bits in one element

  localparam int ArrayLength = 1 << IndexBits;    // Elements per array
  localparam int NumArrays   = 1 << AddressBits;  // Array slots in the store

  typedef logic [AddressBits-1:0] arrayNumT;
  typedef logic [IndexBits-1:0]   indexT;
  typedef logic [DataBits-1:0]    dataT;

  // One extra bit so a completely full array can be represented
  typedef logic [IndexBits:0]     sizeT;

endpackage

`default_nettype wire
